// File: lane_sequencer.f
+incdir+.
verilog/lane_seq_pkg.sv
verilog/lane_req_intake.sv
verilog/lane_cmd_builder.sv
verilog/lane_issue_ctrl.sv
verilog/operand_cmd_regs.sv
verilog/lane_sequencer.sv
verification/lane_sequencer_properties.sv
verification/lane_sequencer_tb.sv

// File: Bender.yml
package:
  name: lane_sequencer

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - verilog/lane_seq_pkg.sv
      - verilog/lane_req_intake.sv
      - verilog/lane_cmd_builder.sv
      - verilog/lane_issue_ctrl.sv
      - verilog/operand_cmd_regs.sv
      - verilog/lane_sequencer.sv
  - target: test
    include_dirs:
      - .
    files:
      - verification/lane_sequencer_properties.sv
      - verification/lane_sequencer_tb.sv

// File: verification/lane_sequencer_tb.sv
//////////////////////////////////////////////////////////////////////
// Lane sequencer testbench
//////////////////////////////////////////////////////////////////////

`default_nettype none

`include "lane_sequencer_cfg.svh"

module lane_sequencer_tb;

  localparam int NQ      = int'(lane_seq_pkg::MASK_M) + 1;
  localparam int TIMEOUT = 50;

  typedef struct packed {
    lane_seq_pkg::vfu_operation_t   op;
    lane_seq_pkg::opreq_cmd_array_t cmd;
    lane_seq_pkg::queue_mask_t      push;
    logic                           muted;
  } expect_t;

  logic                           clk_i;
  logic                           rst_ni;
  lane_seq_pkg::lane_idx_t        lane_id_i;
  lane_seq_pkg::pe_req_t          pe_req_i;
  logic                           pe_req_valid_i;
  logic                           pe_req_ready_o;
  lane_seq_pkg::vinsn_mask_t      pe_vinsn_running_i;
  lane_seq_pkg::vinsn_mask_t      vinsn_done_o;
  lane_seq_pkg::opreq_cmd_array_t operand_request_o;
  lane_seq_pkg::queue_mask_t      operand_request_valid_o;
  lane_seq_pkg::queue_mask_t      operand_request_ready_i;
  lane_seq_pkg::vfu_operation_t   vfu_operation_o;
  logic                           vfu_operation_valid_o;
  lane_seq_pkg::vinsn_mask_t      alu_vinsn_done_i;
  lane_seq_pkg::vinsn_mask_t      mfpu_vinsn_done_i;
  logic                           alu_vinsn_done_o;
  logic                           mfpu_vinsn_done_o;

  expect_t                   exp_q[$];
  expect_t                   got;
  lane_seq_pkg::queue_mask_t prev_valid;
  logic [31:0]               lfsr_state;
  string                     test_name;
  int                        checks;
  int                        errors;
  int                        test_checks;
  int                        test_errors;

  lane_sequencer uut (.*);

  always #50 clk_i = ~clk_i;

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h8020_0003;
    end
    return s >> 1;
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      v          = {v[30:0], lfsr_state[0]};
    end
  endtask

  task automatic check_eq(input string what, input logic [127:0] exp, input logic [127:0] act);
    checks++;
    assert (exp === act) else begin
      errors++;
      $display("[ERROR] %s %s: expected %0h, actual %0h", test_name, what, exp, act);
    end
  endtask

  task automatic abort(input string why);
    $display("%s: timeout, %s", test_name, why);
    $display("CHECKS FAILED");
    $finish;
  endtask

  task automatic begin_test(input string name);
    test_name   = name;
    test_checks = checks;
    test_errors = errors;
  endtask

  task automatic end_test();
    $display("test %s: %0d checks, %0d errors", test_name, checks - test_checks,
             errors - test_errors);
  endtask

  // Expected lane view of a broadcast request
  function automatic expect_t reference(input lane_seq_pkg::pe_req_t r,
                                        input lane_seq_pkg::lane_idx_t lane);
    expect_t     e;
    int unsigned lanes;
    int unsigned vl_lane;
    int unsigned vstart_lane;
    int unsigned per_word;
    lanes       = `LANE_SEQ_NR_LANES;
    vl_lane     = r.vl / lanes + ((lane < r.vl % lanes) ? 1 : 0);
    vstart_lane = r.vstart / lanes + ((lane < r.vstart % lanes) ? 1 : 0);
    // Elements covered by one mask word across all lanes
    per_word    = 8 * lanes * (1 << int'(r.vsew));
    e           = '0;
    e.muted     = (vl_lane == 0);
    e.op.id     = r.id;
    e.op.op     = r.op;
    e.op.vfu    = r.vfu;
    e.op.vm     = r.vm;
    e.op.vd     = r.vd;
    e.op.vsew   = r.vsew;
    e.op.vl     = lane_seq_pkg::vlen_t'(vl_lane);
    e.op.vstart = lane_seq_pkg::vlen_t'(vstart_lane);
    for (int q = 0; q < NQ; q++) begin
      e.cmd[q].id     = r.id;
      e.cmd[q].eew    = r.vsew;
      e.cmd[q].vl     = e.op.vl;
      e.cmd[q].vstart = e.op.vstart;
    end
    e.cmd[lane_seq_pkg::ALU_A].vs      = r.vs1;
    e.cmd[lane_seq_pkg::ALU_A].hazard  = lane_seq_pkg::H_VS1;
    e.cmd[lane_seq_pkg::ALU_B].vs      = r.vs2;
    e.cmd[lane_seq_pkg::ALU_B].hazard  = lane_seq_pkg::H_VS2;
    e.cmd[lane_seq_pkg::MFPU_A].vs     = r.vs1;
    e.cmd[lane_seq_pkg::MFPU_A].hazard = lane_seq_pkg::H_VS1;
    if (r.swap_vs2_vd_op) begin
      e.cmd[lane_seq_pkg::MFPU_B].vs     = r.vd;
      e.cmd[lane_seq_pkg::MFPU_B].hazard = lane_seq_pkg::H_VD;
      e.cmd[lane_seq_pkg::MFPU_C].vs     = r.vs2;
      e.cmd[lane_seq_pkg::MFPU_C].hazard = lane_seq_pkg::H_VS2;
    end else begin
      e.cmd[lane_seq_pkg::MFPU_B].vs     = r.vs2;
      e.cmd[lane_seq_pkg::MFPU_B].hazard = lane_seq_pkg::H_VS2;
      e.cmd[lane_seq_pkg::MFPU_C].vs     = r.vd;
      e.cmd[lane_seq_pkg::MFPU_C].hazard = lane_seq_pkg::H_VD;
    end
    e.cmd[lane_seq_pkg::MASK_M].vs     = `LANE_SEQ_VMASK;
    e.cmd[lane_seq_pkg::MASK_M].hazard = lane_seq_pkg::H_VM;
    e.cmd[lane_seq_pkg::MASK_M].vl     = lane_seq_pkg::vlen_t'((r.vl + per_word - 1) / per_word);
    e.push[lane_seq_pkg::MASK_M] = !r.vm;
    if (r.vfu == lane_seq_pkg::VFU_ALU) begin
      e.push[lane_seq_pkg::ALU_A] = r.use_vs1;
      e.push[lane_seq_pkg::ALU_B] = r.use_vs2;
    end else begin
      e.push[lane_seq_pkg::MFPU_A] = r.use_vs1;
      e.push[lane_seq_pkg::MFPU_B] = r.swap_vs2_vd_op ? r.use_vd_op : r.use_vs2;
      e.push[lane_seq_pkg::MFPU_C] = r.swap_vs2_vd_op ? r.use_vs2 : r.use_vd_op;
    end
    return e;
  endfunction

  task automatic random_req(input lane_seq_pkg::vid_t id, output lane_seq_pkg::pe_req_t r);
    logic [31:0] v;
    r    = '0;
    r.id = id;
    take_bits(6, v);
    r.op = lane_seq_pkg::op_t'(v);
    take_bits(4, v);
    r.vfu = lane_seq_pkg::vfu_e'(v[0]);
    r.vm  = v[1];
    r.swap_vs2_vd_op = v[2];
    take_bits(15, v);
    r.vs1 = v[4:0];
    r.vs2 = v[9:5];
    r.vd  = v[14:10];
    take_bits(5, v);
    {r.use_vs1, r.use_vs2, r.use_vd_op} = v[2:0];
    r.vsew = lane_seq_pkg::sew_e'(v[4:3]);
    take_bits(10, v);
    r.vl = lane_seq_pkg::vlen_t'(v);
    take_bits(5, v);
    r.vstart = lane_seq_pkg::vlen_t'(v);
  endtask

  // Offers a request, waits until the intake takes it, then holds the valid
  task automatic drive_req(input lane_seq_pkg::pe_req_t r, input expect_t e, input int hold);
    int t;
    t = 0;
    @(negedge clk_i);
    pe_req_i       = r;
    pe_req_valid_i = 1'b1;
    if (!e.muted) begin
      exp_q.push_back(e);
    end
    while (!pe_req_ready_o) begin
      @(negedge clk_i);
      t++;
      if (t > TIMEOUT) begin
        abort("request was never accepted");
      end
    end
    repeat (hold) @(negedge clk_i);
    pe_req_valid_i = 1'b0;
  endtask

  task automatic wait_done(input expect_t e);
    int t;
    t = 0;
    if (e.muted) begin
      while (!vinsn_done_o[e.op.id]) begin
        @(negedge clk_i);
        t++;
        if (t > TIMEOUT) begin
          abort("muted instruction was never reported done");
        end
      end
      // A muted issue reports its own ID and nothing else
      check_eq("done mask", lane_seq_pkg::vinsn_mask_t'(1) << e.op.id, vinsn_done_o);
    end else begin
      while (exp_q.size() != 0) begin
        @(posedge clk_i);
        t++;
        if (t > TIMEOUT) begin
          abort("expected operation was never issued");
        end
      end
    end
  endtask

  task automatic run_req(input lane_seq_pkg::pe_req_t r, input int hold);
    expect_t e;
    e = reference(r, lane_id_i);
    drive_req(r, e, hold);
    wait_done(e);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Output comparison
  //////////////////////////////////////////////////////////////////////

  always @(negedge clk_i) begin
    if (rst_ni) begin
      if (vfu_operation_valid_o) begin
        checks++;
        assert (exp_q.size() != 0) else begin
          errors++;
          $display("%s: operation with ID %0d issued while none was expected", test_name,
                   vfu_operation_o.id);
        end
        if (exp_q.size() != 0) begin
          got = exp_q.pop_front();
          check_eq("vfu operation", got.op, vfu_operation_o);
          check_eq("operand request valid", got.push, operand_request_valid_o);
          for (int q = 0; q < NQ; q++) begin
            if (got.push[q]) begin
              check_eq($sformatf("queue %0d command", q), got.cmd[q], operand_request_o[q]);
            end
          end
        end
      end else begin
        // Operand requests only ever come with an issued operation
        assert ((operand_request_valid_o & ~prev_valid) == '0) else begin
          errors++;
          $display("%s: operand request appeared without an operation", test_name);
        end
      end
      prev_valid = operand_request_valid_o;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    lane_seq_pkg::pe_req_t r;
    expect_t               e;
    logic [31:0]           a;
    logic [31:0]           m;
    lane_seq_pkg::vid_t    id;
    clk_i                   = 1'b0;
    rst_ni                  = 1'b0;
    lane_id_i               = 1;
    pe_req_i                = '0;
    pe_req_valid_i          = 1'b0;
    pe_vinsn_running_i      = '0;
    operand_request_ready_i = '1;
    alu_vinsn_done_i        = '0;
    mfpu_vinsn_done_i       = '0;
    prev_valid              = '0;
    lfsr_state              = 32'h05ba_3596;
    checks                  = 0;
    errors                  = 0;
    id                      = '0;
    repeat (2) @(negedge clk_i);
    rst_ni = 1'b1;

    begin_test("reset");
    check_eq("intake ready", 1, pe_req_ready_o);
    check_eq("operation valid", 0, vfu_operation_valid_o);
    check_eq("operand request valid", 0, operand_request_valid_o);
    check_eq("done mask", 0, vinsn_done_o);
    end_test();

    begin_test("random");
    for (int n = 0; n < 40; n++) begin
      random_req(id, r);
      run_req(r, 1);
      id++;
    end
    end_test();

    begin_test("repeated broadcast");
    random_req(id, r);
    r.vl = 100;
    run_req(r, 5);
    id++;
    random_req(id, r);
    r.vl = 100;
    run_req(r, 1);
    id++;
    end_test();

    // With lane 1, a vl of one or zero leaves no element here
    begin_test("muted");
    random_req(id, r);
    r.vl = 1;
    run_req(r, 1);
    id++;
    random_req(id, r);
    r.vl = 0;
    run_req(r, 1);
    id++;
    end_test();

    begin_test("backpressure");
    @(negedge clk_i);
    operand_request_ready_i[lane_seq_pkg::ALU_A] = 1'b0;
    random_req(id, r);
    r.vfu     = lane_seq_pkg::VFU_ALU;
    r.use_vs1 = 1'b1;
    r.vl      = 64;
    run_req(r, 1);
    id++;
    random_req(id, r);
    r.vfu = lane_seq_pkg::VFU_ALU;
    r.vl  = 64;
    e     = reference(r, lane_id_i);
    drive_req(r, e, 1);
    id++;
    check_eq("intake ready while blocked", 0, pe_req_ready_o);
    repeat (3) @(posedge clk_i);
    check_eq("operations pending while blocked", 1, exp_q.size());
    @(negedge clk_i);
    operand_request_ready_i[lane_seq_pkg::ALU_A] = 1'b1;
    wait_done(e);
    end_test();

    begin_test("unit done");
    for (int n = 0; n < 4; n++) begin
      @(negedge clk_i);
      take_bits(8, a);
      take_bits(8, m);
      alu_vinsn_done_i  = a[7:0];
      mfpu_vinsn_done_i = m[7:0];
      @(negedge clk_i);
      check_eq("done mask", a[7:0] | m[7:0], vinsn_done_o);
      check_eq("alu done", |a[7:0], alu_vinsn_done_o);
      check_eq("mfpu done", |m[7:0], mfpu_vinsn_done_o);
      alu_vinsn_done_i  = '0;
      mfpu_vinsn_done_i = '0;
    end
    end_test();

    $display("total: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verification/lane_sequencer_properties.sv
//////////////////////////////////////////////////////////////////////
// Lane sequencer port properties
//////////////////////////////////////////////////////////////////////

`default_nettype none

module lane_sequencer_properties (
  input logic                           clk_i,
  input logic                           rst_ni,
  input lane_seq_pkg::vfu_operation_t   vfu_operation_i,
  input logic                           vfu_operation_valid_i,
  input lane_seq_pkg::opreq_cmd_array_t operand_request_i,
  input lane_seq_pkg::queue_mask_t      operand_request_valid_i,
  input lane_seq_pkg::queue_mask_t      operand_request_ready_i
);

  localparam int NQ = int'(lane_seq_pkg::MASK_M) + 1;

  // Nothing may be offered while the lane is held in reset
  reset_quiet: assert property (@(posedge clk_i)
      !rst_ni |-> !vfu_operation_valid_i && operand_request_valid_i == '0)
    else $error("valid output high during reset");

  // One broadcast gives one pulse, never a second one for the same ID
  single_issue: assert property (@(posedge clk_i) disable iff (!rst_ni)
      vfu_operation_valid_i |=>
      !(vfu_operation_valid_i && vfu_operation_i.id == $past(vfu_operation_i.id)))
    else $error("operation issued twice in a row with the same ID");

  for (genvar q = 0; q < NQ; q++) begin : g_queue
    // A waiting operand request must hold still until the queue takes it
    opreq_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
        operand_request_valid_i[q] && !operand_request_ready_i[q] |=>
        operand_request_valid_i[q] && $stable(operand_request_i[q]))
      else $error("operand request %0d changed while it waited", q);
  end

endmodule

bind lane_sequencer lane_sequencer_properties i_properties (
  .clk_i                  (clk_i),
  .rst_ni                 (rst_ni),
  .vfu_operation_i        (vfu_operation_o),
  .vfu_operation_valid_i  (vfu_operation_valid_o),
  .operand_request_i      (operand_request_o),
  .operand_request_valid_i(operand_request_valid_o),
  .operand_request_ready_i(operand_request_ready_i)
);

`default_nettype wire

// File: verilog/lane_sequencer.sv
//////////////////////////////////////////////////////////////////////
// Per-lane instruction sequencer
//////////////////////////////////////////////////////////////////////

`default_nettype none

module lane_sequencer (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  lane_seq_pkg::lane_idx_t        lane_id_i,
  // Main sequencer side
  input  lane_seq_pkg::pe_req_t          pe_req_i,
  input  logic                           pe_req_valid_i,
  output logic                           pe_req_ready_o,
  input  lane_seq_pkg::vinsn_mask_t      pe_vinsn_running_i,
  output lane_seq_pkg::vinsn_mask_t      vinsn_done_o,
  // Operand requester side
  output lane_seq_pkg::opreq_cmd_array_t operand_request_o,
  output lane_seq_pkg::queue_mask_t      operand_request_valid_o,
  input  lane_seq_pkg::queue_mask_t      operand_request_ready_i,
  // Functional units
  output lane_seq_pkg::vfu_operation_t   vfu_operation_o,
  output logic                           vfu_operation_valid_o,
  input  lane_seq_pkg::vinsn_mask_t      alu_vinsn_done_i,
  input  lane_seq_pkg::vinsn_mask_t      mfpu_vinsn_done_i,
  output logic                           alu_vinsn_done_o,
  output logic                           mfpu_vinsn_done_o
);

  lane_seq_pkg::pe_req_t          req;
  logic                           req_valid;
  logic                           req_ready;
  lane_seq_pkg::opreq_cmd_array_t cand_cmd;
  lane_seq_pkg::queue_mask_t      cand_push;
  lane_seq_pkg::queue_mask_t      push;
  lane_seq_pkg::vfu_operation_t   cand_op;
  logic                           muted;

  lane_req_intake i_intake (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .pe_req_i      (pe_req_i),
    .pe_req_valid_i(pe_req_valid_i),
    .pe_req_ready_o(pe_req_ready_o),
    .req_o         (req),
    .req_valid_o   (req_valid),
    .req_ready_i   (req_ready)
  );

  lane_cmd_builder i_builder (
    .lane_id_i(lane_id_i),
    .req_i    (req),
    .cmd_o    (cand_cmd),
    .push_o   (cand_push),
    .vfu_op_o (cand_op),
    .muted_o  (muted)
  );

  lane_issue_ctrl i_issue (
    .clk_i                (clk_i),
    .rst_ni               (rst_ni),
    .req_i                (req),
    .req_valid_i          (req_valid),
    .req_ready_o          (req_ready),
    .queue_valid_i        (operand_request_valid_o),
    .push_i               (cand_push),
    .push_o               (push),
    .vfu_op_i             (cand_op),
    .muted_i              (muted),
    .vfu_operation_o      (vfu_operation_o),
    .vfu_operation_valid_o(vfu_operation_valid_o),
    .pe_vinsn_running_i   (pe_vinsn_running_i),
    .alu_vinsn_done_i     (alu_vinsn_done_i),
    .mfpu_vinsn_done_i    (mfpu_vinsn_done_i),
    .vinsn_done_o         (vinsn_done_o),
    .alu_vinsn_done_o     (alu_vinsn_done_o),
    .mfpu_vinsn_done_o    (mfpu_vinsn_done_o)
  );

  operand_cmd_regs i_cmd_regs (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .cmd_i  (cand_cmd),
    .push_i (push),
    .ready_i(operand_request_ready_i),
    .cmd_o  (operand_request_o),
    .valid_o(operand_request_valid_o)
  );

endmodule

`default_nettype wire

// File: verilog/operand_cmd_regs.sv
//////////////////////////////////////////////////////////////////////
// Operand request registers
//////////////////////////////////////////////////////////////////////

`default_nettype none

module operand_cmd_regs (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  lane_seq_pkg::opreq_cmd_array_t cmd_i,
  input  lane_seq_pkg::queue_mask_t      push_i,
  input  lane_seq_pkg::queue_mask_t      ready_i,
  output lane_seq_pkg::opreq_cmd_array_t cmd_o,
  output lane_seq_pkg::queue_mask_t      valid_o
);

  lane_seq_pkg::queue_mask_t valid_d;

  // A new command replaces the one being taken in the same cycle
  always_comb begin
    for (int q = 0; q <= int'(lane_seq_pkg::MASK_M); q++) begin
      if (push_i[q]) begin
        valid_d[q] = 1'b1;
      end else if (ready_i[q]) begin
        valid_d[q] = 1'b0;
      end else begin
        valid_d[q] = valid_o[q];
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_o <= '0;
    end else begin
      valid_o <= valid_d;
    end
  end

  // Each queue has its own holding register
  always_ff @(posedge clk_i) begin
    for (int q = 0; q <= int'(lane_seq_pkg::MASK_M); q++) begin
      if (push_i[q]) begin
        cmd_o[q] <= cmd_i[q];
      end
    end
  end

endmodule

`default_nettype wire

// File: verilog/lane_issue_ctrl.sv
//////////////////////////////////////////////////////////////////////
// Lane issue control
//////////////////////////////////////////////////////////////////////

`default_nettype none

module lane_issue_ctrl (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  lane_seq_pkg::pe_req_t        req_i,
  input  logic                         req_valid_i,
  output logic                         req_ready_o,
  input  lane_seq_pkg::queue_mask_t    queue_valid_i,
  input  lane_seq_pkg::queue_mask_t    push_i,
  output lane_seq_pkg::queue_mask_t    push_o,
  input  lane_seq_pkg::vfu_operation_t vfu_op_i,
  input  logic                         muted_i,
  output lane_seq_pkg::vfu_operation_t vfu_operation_o,
  output logic                         vfu_operation_valid_o,
  input  lane_seq_pkg::vinsn_mask_t    pe_vinsn_running_i,
  input  lane_seq_pkg::vinsn_mask_t    alu_vinsn_done_i,
  input  lane_seq_pkg::vinsn_mask_t    mfpu_vinsn_done_i,
  output lane_seq_pkg::vinsn_mask_t    vinsn_done_o,
  output logic                         alu_vinsn_done_o,
  output logic                         mfpu_vinsn_done_o
);

  lane_seq_pkg::queue_mask_t unit_queues;
  lane_seq_pkg::vinsn_mask_t running_d, running_q;
  lane_seq_pkg::vinsn_mask_t done_d;
  logic                      issue;

  // Queues the request's unit reads from
  always_comb begin
    unit_queues                       = '0;
    unit_queues[lane_seq_pkg::MASK_M] = 1'b1;
    if (req_i.vfu == lane_seq_pkg::VFU_ALU) begin
      unit_queues[lane_seq_pkg::ALU_A] = 1'b1;
      unit_queues[lane_seq_pkg::ALU_B] = 1'b1;
    end else begin
      unit_queues[lane_seq_pkg::MFPU_A] = 1'b1;
      unit_queues[lane_seq_pkg::MFPU_B] = 1'b1;
      unit_queues[lane_seq_pkg::MFPU_C] = 1'b1;
    end
  end

  // A pending operand request blocks the whole unit
  assign req_ready_o = !(|(queue_valid_i & unit_queues));

  always_comb begin
    running_d = running_q & pe_vinsn_running_i;
    done_d    = alu_vinsn_done_i | mfpu_vinsn_done_i;
    push_o    = '0;

    // A request whose ID still runs is consumed and dropped
    issue = req_valid_i && req_ready_o && !running_d[req_i.id];

    if (issue) begin
      if (muted_i) begin
        // Nothing to do in this lane, report it done right away
        done_d[req_i.id] = 1'b1;
      end else begin
        running_d[req_i.id] = 1'b1;
        push_o              = push_i;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      running_q             <= '0;
      vinsn_done_o          <= '0;
      vfu_operation_valid_o <= 1'b0;
      alu_vinsn_done_o      <= 1'b0;
      mfpu_vinsn_done_o     <= 1'b0;
    end else begin
      running_q             <= running_d;
      vinsn_done_o          <= done_d;
      vfu_operation_valid_o <= issue && !muted_i;
      alu_vinsn_done_o      <= |alu_vinsn_done_i;
      mfpu_vinsn_done_o     <= |mfpu_vinsn_done_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (issue && !muted_i) begin
      vfu_operation_o <= vfu_op_i;
    end
  end

endmodule

`default_nettype wire

// File: verilog/lane_cmd_builder.sv
//////////////////////////////////////////////////////////////////////
// Lane command builder
//////////////////////////////////////////////////////////////////////

`default_nettype none

`include "lane_sequencer_cfg.svh"

module lane_cmd_builder (
  input  lane_seq_pkg::lane_idx_t        lane_id_i,
  input  lane_seq_pkg::pe_req_t          req_i,
  output lane_seq_pkg::opreq_cmd_array_t cmd_o,
  output lane_seq_pkg::queue_mask_t      push_o,
  output lane_seq_pkg::vfu_operation_t   vfu_op_o,
  output logic                           muted_o
);

  localparam int unsigned LANE_W = $clog2(`LANE_SEQ_NR_LANES);

  lane_seq_pkg::vlen_t lane_vl;
  lane_seq_pkg::vlen_t lane_vstart;
  logic [3:0]          mask_shift;
  lane_seq_pkg::vlen_t mask_low;
  lane_seq_pkg::vlen_t mask_vl;

  // Elements are spread round robin, so the first lanes take one extra
  // element when the count does not divide evenly
  function automatic lane_seq_pkg::vlen_t lane_share(input lane_seq_pkg::vlen_t total,
                                                     input lane_seq_pkg::lane_idx_t lane);
    lane_seq_pkg::vlen_t share;
    share = total >> LANE_W;
    if (lane < total[LANE_W-1:0]) begin
      share = share + lane_seq_pkg::vlen_t'(1);
    end
    return share;
  endfunction

  assign lane_vl     = lane_share(req_i.vl, lane_id_i);
  assign lane_vstart = lane_share(req_i.vstart, lane_id_i);
  assign muted_o     = (lane_vl == '0);

  // One mask word covers 8 * NR_LANES * 2^vsew elements, rounded up
  assign mask_shift = 4'(3 + LANE_W) + 4'(req_i.vsew);
  assign mask_low   = req_i.vl & ((lane_seq_pkg::vlen_t'(1) << mask_shift) -
                                  lane_seq_pkg::vlen_t'(1));
  assign mask_vl    = (req_i.vl >> mask_shift) +
                      ((mask_low != '0) ? lane_seq_pkg::vlen_t'(1) : lane_seq_pkg::vlen_t'(0));

  always_comb begin
    vfu_op_o.id     = req_i.id;
    vfu_op_o.op     = req_i.op;
    vfu_op_o.vfu    = req_i.vfu;
    vfu_op_o.vm     = req_i.vm;
    vfu_op_o.vd     = req_i.vd;
    vfu_op_o.vsew   = req_i.vsew;
    vfu_op_o.vl     = lane_vl;
    vfu_op_o.vstart = lane_vstart;
  end

  //////////////////////////////////////////////////////////////////////
  // Operand request commands
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    for (int q = 0; q <= int'(lane_seq_pkg::MASK_M); q++) begin
      cmd_o[q].id     = req_i.id;
      cmd_o[q].eew    = req_i.vsew;
      cmd_o[q].vl     = lane_vl;
      cmd_o[q].vstart = lane_vstart;
    end

    cmd_o[lane_seq_pkg::ALU_A].vs      = req_i.vs1;
    cmd_o[lane_seq_pkg::ALU_A].hazard  = lane_seq_pkg::H_VS1;
    cmd_o[lane_seq_pkg::ALU_B].vs      = req_i.vs2;
    cmd_o[lane_seq_pkg::ALU_B].hazard  = lane_seq_pkg::H_VS2;
    cmd_o[lane_seq_pkg::MFPU_A].vs     = req_i.vs1;
    cmd_o[lane_seq_pkg::MFPU_A].hazard = lane_seq_pkg::H_VS1;

    // Fused multiply-add forms can ask for vd on the B port and vs2 on C
    cmd_o[lane_seq_pkg::MFPU_B].vs     = req_i.swap_vs2_vd_op ? req_i.vd : req_i.vs2;
    cmd_o[lane_seq_pkg::MFPU_B].hazard = req_i.swap_vs2_vd_op ? lane_seq_pkg::H_VD :
                                                                lane_seq_pkg::H_VS2;
    cmd_o[lane_seq_pkg::MFPU_C].vs     = req_i.swap_vs2_vd_op ? req_i.vs2 : req_i.vd;
    cmd_o[lane_seq_pkg::MFPU_C].hazard = req_i.swap_vs2_vd_op ? lane_seq_pkg::H_VS2 :
                                                                lane_seq_pkg::H_VD;

    cmd_o[lane_seq_pkg::MASK_M].vs     = lane_seq_pkg::vreg_t'(`LANE_SEQ_VMASK);
    cmd_o[lane_seq_pkg::MASK_M].hazard = lane_seq_pkg::H_VM;
    cmd_o[lane_seq_pkg::MASK_M].vl     = mask_vl;

    push_o                       = '0;
    push_o[lane_seq_pkg::MASK_M] = !req_i.vm;
    if (req_i.vfu == lane_seq_pkg::VFU_ALU) begin
      push_o[lane_seq_pkg::ALU_A] = req_i.use_vs1;
      push_o[lane_seq_pkg::ALU_B] = req_i.use_vs2;
    end else begin
      push_o[lane_seq_pkg::MFPU_A] = req_i.use_vs1;
      push_o[lane_seq_pkg::MFPU_B] = req_i.swap_vs2_vd_op ? req_i.use_vd_op : req_i.use_vs2;
      push_o[lane_seq_pkg::MFPU_C] = req_i.swap_vs2_vd_op ? req_i.use_vs2 : req_i.use_vd_op;
    end
  end

endmodule

`default_nettype wire

// File: verilog/lane_req_intake.sv
//////////////////////////////////////////////////////////////////////
// Lane request intake
//////////////////////////////////////////////////////////////////////

`default_nettype none

module lane_req_intake (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  lane_seq_pkg::pe_req_t pe_req_i,
  input  logic                  pe_req_valid_i,
  output logic                  pe_req_ready_o,
  output lane_seq_pkg::pe_req_t req_o,
  output logic                  req_valid_o,
  input  logic                  req_ready_i
);

  lane_seq_pkg::pe_req_t req_q;
  logic                  full_d, full_q;

  // Broadcast filter state
  lane_seq_pkg::vid_t last_id_d, last_id_q;
  logic               filter_d, filter_q;

  logic valid_msk;
  logic accept;

  // The main sequencer keeps the valid high until every lane took the request,
  // so a broadcast of the ID we already took must not be taken again
  assign valid_msk = pe_req_valid_i && !(filter_q && (pe_req_i.id == last_id_q));

  assign pe_req_ready_o = !full_q;
  assign accept         = valid_msk && pe_req_ready_o;

  // An empty register lets the request fall through in the same cycle
  assign req_o       = full_q ? req_q : pe_req_i;
  assign req_valid_o = full_q || valid_msk;

  always_comb begin
    full_d    = full_q;
    last_id_d = last_id_q;
    filter_d  = filter_q;

    if (full_q && req_ready_i) begin
      full_d = 1'b0;
    end else if (accept && !req_ready_i) begin
      full_d = 1'b1;
    end

    if (accept) begin
      last_id_d = pe_req_i.id;
      filter_d  = 1'b1;
    end

    // A drop of the valid ends the broadcast
    if (!pe_req_valid_i) begin
      filter_d = 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      full_q    <= 1'b0;
      last_id_q <= '0;
      filter_q  <= 1'b0;
    end else begin
      full_q    <= full_d;
      last_id_q <= last_id_d;
      filter_q  <= filter_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept && !req_ready_i) begin
      req_q <= pe_req_i;
    end
  end

endmodule

`default_nettype wire

// File: verilog/lane_seq_pkg.sv
//////////////////////////////////////////////////////////////////////
// Lane sequencer types
//////////////////////////////////////////////////////////////////////

`default_nettype none

`include "lane_sequencer_cfg.svh"

package lane_seq_pkg;

  typedef logic [$clog2(`LANE_SEQ_NR_LANES)-1:0] lane_idx_t;
  typedef logic [$clog2(`LANE_SEQ_NR_VINSN)-1:0] vid_t;
  typedef logic [`LANE_SEQ_NR_VINSN-1:0]         vinsn_mask_t;
  typedef logic [`LANE_SEQ_VLEN_W-1:0]           vlen_t;
  typedef logic [`LANE_SEQ_VREG_W-1:0]           vreg_t;
  typedef logic [`LANE_SEQ_OP_W-1:0]             op_t;

  typedef enum logic [1:0] {EW8, EW16, EW32, EW64} sew_e;
  typedef enum logic {VFU_ALU, VFU_MFPU} vfu_e;
  typedef enum logic [1:0] {H_VS1, H_VS2, H_VD, H_VM} hazard_e;

  // Operand queues of the two units, the mask queue is shared
  typedef enum logic [2:0] {ALU_A, ALU_B, MFPU_A, MFPU_B, MFPU_C, MASK_M} opqueue_e;

  typedef logic [int'(MASK_M):0] queue_mask_t;

  // Request broadcast by the main sequencer
  typedef struct packed {
    vid_t  id;
    op_t   op;
    vfu_e  vfu;
    logic  vm;
    vreg_t vs1;
    vreg_t vs2;
    vreg_t vd;
    logic  use_vs1;
    logic  use_vs2;
    logic  use_vd_op;
    logic  swap_vs2_vd_op;
    sew_e  vsew;
    vlen_t vl;
    vlen_t vstart;
  } pe_req_t;

  // Operation for the lane's functional unit, with the lane share of vl
  typedef struct packed {
    vid_t  id;
    op_t   op;
    vfu_e  vfu;
    logic  vm;
    vreg_t vd;
    sew_e  vsew;
    vlen_t vl;
    vlen_t vstart;
  } vfu_operation_t;

  typedef struct packed {
    vid_t    id;
    vreg_t   vs;
    sew_e    eew;
    vlen_t   vl;
    vlen_t   vstart;
    hazard_e hazard;
  } opreq_cmd_t;

  typedef opreq_cmd_t [int'(MASK_M):0] opreq_cmd_array_t;

endpackage

`default_nettype wire

// File: lane_sequencer_cfg.svh
//////////////////////////////////////////////////////////////////////
// Lane sequencer configuration
//////////////////////////////////////////////////////////////////////

`ifndef LANE_SEQUENCER_CFG_SVH
`define LANE_SEQUENCER_CFG_SVH

// Number of lanes, must be a power of two
`define LANE_SEQ_NR_LANES 4

// Instruction IDs that can be in flight at once
`define LANE_SEQ_NR_VINSN 8

// Vector length and start element width
`define LANE_SEQ_VLEN_W 16

// Register index and opcode widths
`define LANE_SEQ_VREG_W 5
`define LANE_SEQ_OP_W 6

// Register that holds the mask
`define LANE_SEQ_VMASK 0

`endif
